// File: src/rvPkg.sv
`default_nettype none

package rvPkg;

    // Datapath widths
    localparam int xlen = 32;
    localparam int regAddrW = 5;

    // Data memory depth in 32-bit words, byte address wraps at 4 * memWords
    localparam int memWords = 256;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        opImm   = 7'b0010011,
        opReg   = 7'b0110011,
        opLui   = 7'b0110111,
        opJal   = 7'b1101111,
        opLoad  = 7'b0000011,
        opStore = 7'b0100011
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluSll  = 4'd2,
        aluSlt  = 4'd3,
        aluSltu = 4'd4,
        aluXor  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluOr   = 4'd8,
        aluAnd  = 4'd9
    } aluOpE;

    // Write-back source
    typedef enum logic [1:0] {
        wbAlu    = 2'd0,
        wbImm    = 2'd1,
        wbPcNext = 2'd2,
        wbMem    = 2'd3
    } wbSelE;

    // Encoded like funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } memSizeE;

endpackage

`default_nettype wire

// File: src/controlUnit.sv
`default_nettype none

module controlUnit (
    input  wire [31:0]       instruction,
    output rvPkg::aluOpE     aluOp,
    output logic             aluSrcImm,
    output rvPkg::wbSelE     wbSel,
    output logic             regWe,
    output logic             memWe,
    output rvPkg::memSizeE   memSize,
    output logic             loadUnsigned,
    output logic             illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       altFunct7;
    logic       plainFunct7;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    // Only zero and 0100000 are meaningful funct7 values
    assign plainFunct7 = (funct7 == 7'b0000000);
    assign altFunct7 = (funct7 == 7'b0100000);

    always_comb begin
        aluOp = rvPkg::aluAdd;
        aluSrcImm = 1'b0;
        wbSel = rvPkg::wbAlu;
        regWe = 1'b0;
        memWe = 1'b0;
        memSize = rvPkg::sizeWord;
        loadUnsigned = 1'b0;
        illegal = 1'b0;

        case (opcode)
            rvPkg::opImm, rvPkg::opReg: begin
                aluSrcImm = (opcode == rvPkg::opImm);
                regWe = 1'b1;
                case (funct3)
                    3'b000: aluOp = (opcode == rvPkg::opReg && altFunct7) ?
                                    rvPkg::aluSub : rvPkg::aluAdd;
                    3'b001: aluOp = rvPkg::aluSll;
                    3'b010: aluOp = rvPkg::aluSlt;
                    3'b011: aluOp = rvPkg::aluSltu;
                    3'b100: aluOp = rvPkg::aluXor;
                    3'b101: aluOp = altFunct7 ? rvPkg::aluSra : rvPkg::aluSrl;
                    3'b110: aluOp = rvPkg::aluOr;
                    default: aluOp = rvPkg::aluAnd;
                endcase
                // funct7 matters for every OP and for the immediate shifts
                if (opcode == rvPkg::opReg || funct3 == 3'b001 || funct3 == 3'b101) begin
                    if (funct3 == 3'b000 && opcode == rvPkg::opReg || funct3 == 3'b101) begin
                        illegal = !(plainFunct7 || altFunct7);
                    end else begin
                        illegal = !plainFunct7;
                    end
                end
            end
            rvPkg::opLui: begin
                wbSel = rvPkg::wbImm;
                regWe = 1'b1;
            end
            rvPkg::opJal: begin
                wbSel = rvPkg::wbPcNext;
                regWe = 1'b1;
            end
            rvPkg::opLoad: begin
                aluSrcImm = 1'b1;
                wbSel = rvPkg::wbMem;
                memSize = rvPkg::memSizeE'(funct3[1:0]);
                loadUnsigned = funct3[2];
                // LBU and LHU only, no LWU on RV32
                illegal = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
                regWe = 1'b1;
            end
            rvPkg::opStore: begin
                aluSrcImm = 1'b1;
                memSize = rvPkg::memSizeE'(funct3[1:0]);
                illegal = funct3[2] || (funct3[1:0] == 2'b11);
                memWe = 1'b1;
            end
            default: illegal = 1'b1;
        endcase

        // Nothing retires from an illegal instruction
        if (illegal) begin
            regWe = 1'b0;
            memWe = 1'b0;
        end

        if (!$isunknown(instruction)) begin
            assert (!$isunknown({aluOp, aluSrcImm, wbSel, regWe, memWe, memSize,
                                 loadUnsigned, illegal}))
                else $error("controlUnit: unknown decode for known instruction");
        end
    end

endmodule

`default_nettype wire

// File: src/immediateGenerator.sv
`default_nettype none

module immediateGenerator (
    input  wire [31:0] instruction,
    output logic [31:0] imm
);

    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immU;
    logic [31:0] immJ;

    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immU = {instruction[31:12], 12'h000};

    // J format scatters the offset bits, bit 0 is always zero
    assign immJ = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                   instruction[30:21], 1'b0};

    always_comb begin
        case (instruction[6:0])
            rvPkg::opImm, rvPkg::opLoad: imm = immI;
            rvPkg::opStore:              imm = immS;
            rvPkg::opLui:                imm = immU;
            rvPkg::opJal:                imm = immJ;
            default:                     imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/alu.sv
`default_nettype none

module alu (
    input  wire rvPkg::aluOpE          aluOp,
    input  wire [rvPkg::xlen-1:0]      left,
    input  wire [rvPkg::xlen-1:0]      right,
    output logic [rvPkg::xlen-1:0]     result
);

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    // Only the low five bits count for shifts
    assign shamt = right[4:0];

    assign lessSigned = $signed(left) < $signed(right);
    assign lessUnsigned = left < right;

    always_comb begin
        case (aluOp)
            rvPkg::aluAdd:  result = left + right;
            rvPkg::aluSub:  result = left - right;
            rvPkg::aluSll:  result = left << shamt;
            rvPkg::aluSlt:  result = {{(rvPkg::xlen-1){1'b0}}, lessSigned};
            rvPkg::aluSltu: result = {{(rvPkg::xlen-1){1'b0}}, lessUnsigned};
            rvPkg::aluXor:  result = left ^ right;
            rvPkg::aluSrl:  result = left >> shamt;
            rvPkg::aluSra:  result = $unsigned($signed(left) >>> shamt);
            rvPkg::aluOr:   result = left | right;
            rvPkg::aluAnd:  result = left & right;
            default:        result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/registerFile.sv
`default_nettype none

module registerFile (
    input  wire                        clk,
    input  wire                        rstN,
    input  wire [rvPkg::regAddrW-1:0]  rs1Addr,
    input  wire [rvPkg::regAddrW-1:0]  rs2Addr,
    input  wire [rvPkg::regAddrW-1:0]  rdAddr,
    input  wire                        we,
    input  wire [rvPkg::xlen-1:0]      rdData,
    output logic [rvPkg::xlen-1:0]     rs1Data,
    output logic [rvPkg::xlen-1:0]     rs2Data
);

    // x0 has no storage
    logic [rvPkg::xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rdAddr != '0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

    // A write aimed at x0 must not show up on the next read of x0
    assert property (@(posedge clk) disable iff (!rstN)
        (we && rdAddr == '0) |=> (rs1Addr != '0 || rs1Data == '0))
        else $error("registerFile: x0 read back nonzero after write");

endmodule

`default_nettype wire

// File: src/dataMemory.sv
`default_nettype none

module dataMemory (
    input  wire                        clk,
    input  wire                        we,
    input  wire rvPkg::memSizeE        size,
    input  wire                        loadUnsigned,
    input  wire [rvPkg::xlen-1:0]      addr,
    input  wire [rvPkg::xlen-1:0]      wdata,
    output logic [rvPkg::xlen-1:0]     rdata
);

    logic [31:0] mem [rvPkg::memWords];
    logic [$clog2(rvPkg::memWords)-1:0] wordIdx;
    logic [31:0] word;
    logic [7:0]  loadByte;
    logic [15:0] loadHalf;

    // Upper address bits wrap around the array
    assign wordIdx = addr[$clog2(rvPkg::memWords)+1:2];
    assign word = mem[wordIdx];

    always_ff @(posedge clk) begin
        if (we) begin
            case (size)
                rvPkg::sizeByte: mem[wordIdx][{addr[1:0], 3'b000} +: 8] <= wdata[7:0];
                rvPkg::sizeHalf: mem[wordIdx][{addr[1], 4'b0000} +: 16] <= wdata[15:0];
                default:         mem[wordIdx] <= wdata;
            endcase
        end
    end

    // Lane select for sub-word loads
    assign loadByte = word[{addr[1:0], 3'b000} +: 8];
    assign loadHalf = word[{addr[1], 4'b0000} +: 16];

    always_comb begin
        case (size)
            rvPkg::sizeByte:
                rdata = {{24{loadByte[7] & !loadUnsigned}}, loadByte};
            rvPkg::sizeHalf:
                rdata = {{16{loadHalf[15] & !loadUnsigned}}, loadHalf};
            default:
                rdata = word;
        endcase
    end

    assert property (@(posedge clk)
        we |-> (size == rvPkg::sizeByte) ||
               (size == rvPkg::sizeHalf && !addr[0]) ||
               (size == rvPkg::sizeWord && addr[1:0] == 2'b00))
        else $error("dataMemory: misaligned store");

endmodule

`default_nettype wire

// File: src/singleCycleCore.sv
`default_nettype none

module singleCycleCore (
    input  wire                        clk,
    input  wire                        rstN,
    input  wire [rvPkg::xlen-1:0]      instruction,
    input  wire [rvPkg::xlen-1:0]      pcNext,
    output logic                       wbEn,
    output logic [rvPkg::regAddrW-1:0] wbAddr,
    output logic [rvPkg::xlen-1:0]     wbData,
    output logic                       memWe,
    output logic [rvPkg::xlen-1:0]     memAddr,
    output logic [rvPkg::xlen-1:0]     memWdata,
    output logic                       illegal
);

    logic [rvPkg::regAddrW-1:0] rd;
    logic [rvPkg::regAddrW-1:0] rs1;
    logic [rvPkg::regAddrW-1:0] rs2;

    rvPkg::aluOpE   aluOp;
    rvPkg::wbSelE   wbSel;
    rvPkg::memSizeE memSize;
    logic           aluSrcImm;
    logic           regWe;
    logic           memWeDec;
    logic           loadUnsigned;

    logic [rvPkg::xlen-1:0] imm;
    logic [rvPkg::xlen-1:0] rs1Data;
    logic [rvPkg::xlen-1:0] rs2Data;
    logic [rvPkg::xlen-1:0] aluRight;
    logic [rvPkg::xlen-1:0] aluResult;
    logic [rvPkg::xlen-1:0] loadData;

    assign rd = instruction[11:7];
    assign rs1 = instruction[19:15];
    assign rs2 = instruction[24:20];

    controlUnit u_controlUnit (
        .instruction  (instruction),
        .aluOp        (aluOp),
        .aluSrcImm    (aluSrcImm),
        .wbSel        (wbSel),
        .regWe        (regWe),
        .memWe        (memWeDec),
        .memSize      (memSize),
        .loadUnsigned (loadUnsigned),
        .illegal      (illegal)
    );

    immediateGenerator u_immediateGenerator (
        .instruction (instruction),
        .imm         (imm)
    );

    registerFile u_registerFile (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (rs1),
        .rs2Addr (rs2),
        .rdAddr  (rd),
        .we      (wbEn),
        .rdData  (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    // Immediate forms and memory addressing use imm on the right
    assign aluRight = aluSrcImm ? imm : rs2Data;

    alu u_alu (
        .aluOp  (aluOp),
        .left   (rs1Data),
        .right  (aluRight),
        .result (aluResult)
    );

    dataMemory u_dataMemory (
        .clk          (clk),
        .we           (memWe),
        .size         (memSize),
        .loadUnsigned (loadUnsigned),
        .addr         (aluResult),
        .wdata        (rs2Data),
        .rdata        (loadData)
    );

    always_comb begin
        case (wbSel)
            rvPkg::wbImm:    wbData = imm;
            rvPkg::wbPcNext: wbData = pcNext;
            rvPkg::wbMem:    wbData = loadData;
            default:         wbData = aluResult;
        endcase
    end

    // No state changes while held in reset
    assign wbEn = regWe & rstN;
    assign memWe = memWeDec & rstN;

    // Trace shows exactly what the register file and memory receive
    assign wbAddr = rd;
    assign memAddr = aluResult;
    assign memWdata = rs2Data;

    // A retired register write is visible to the next instruction's rs1 read
    assert property (@(posedge clk) disable iff (!rstN)
        (wbEn && wbAddr != '0) ##1 (rs1 == $past(wbAddr)) |-> rs1Data == $past(wbData))
        else $error("singleCycleCore: write-back not visible on next read");

endmodule

`default_nettype wire

// File: sim/coreTb.sv
`default_nettype none

module coreTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clkPeriod = 100;
    localparam int rounds = 4;
    // About 95 instructions per round over all tests, plus the fixed ones
    localparam int instrBudget = 95 * rounds + 47;
    localparam int watchdogNs = instrBudget * 200 * clkPeriod + 50 * clkPeriod;

    localparam logic [6:0] opImmC = 7'b0010011;
    localparam logic [6:0] opRegC = 7'b0110011;
    localparam logic [6:0] opLuiC = 7'b0110111;
    localparam logic [6:0] opJalC = 7'b1101111;
    localparam logic [6:0] opLoadC = 7'b0000011;
    localparam logic [6:0] opStoreC = 7'b0100011;
    localparam logic [6:0] opBranchC = 7'b1100011;

    localparam logic [2:0] f3Add = 3'b000;
    localparam logic [2:0] f3Byte = 3'b000;
    localparam logic [2:0] f3Half = 3'b001;
    localparam logic [2:0] f3Word = 3'b010;
    localparam logic [2:0] f3ByteU = 3'b100;
    localparam logic [2:0] f3HalfU = 3'b101;
    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt = 7'b0100000;

    logic        clk;
    logic        rstN;
    logic [31:0] instruction;
    logic [31:0] pcNext;
    logic        wbEn;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic        memWe;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic        illegal;

    // Reference state
    logic [31:0] modelReg [32];
    logic [7:0]  modelMem [1024];
    logic [31:0] rngState;
    logic [31:0] pendingPc;
    string       testName;

    singleCycleCore u_singleCycleCore (
        .clk         (clk),
        .rstN        (rstN),
        .instruction (instruction),
        .pcNext      (pcNext),
        .wbEn        (wbEn),
        .wbAddr      (wbAddr),
        .wbData      (wbData),
        .memWe       (memWe),
        .memAddr     (memAddr),
        .memWdata    (memWdata),
        .illegal     (illegal)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // Any of x1 to x31
    function automatic logic [4:0] randomReg();
        logic [31:0] r;
        r = nextRandom();
        return 5'(r % 31) + 5'd1;
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opRegC};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStoreC};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, opLuiC};
    endfunction

    // Offset bit 0 is implied zero
    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opJalC};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // RV32I integer result for funct3 plus the funct7 alternate bit
    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $unsigned($signed(a) >>> b[4:0]);
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] readModel(input logic [31:0] addr, input int bytes,
                                              input logic unsignedLoad);
        logic [31:0] v;
        logic [9:0]  a;
        v = '0;
        for (int i = 0; i < bytes; i++) begin
            a = 10'(addr + 32'(i));
            v[8*i +: 8] = modelMem[a];
        end
        if (bytes == 1) begin
            return unsignedLoad ? {24'b0, v[7:0]} : {{24{v[7]}}, v[7:0]};
        end
        if (bytes == 2) begin
            return unsignedLoad ? {16'b0, v[15:0]} : {{16{v[15]}}, v[15:0]};
        end
        return v;
    endfunction

    function automatic void writeModel(input logic [31:0] addr, input logic [31:0] data,
                                       input int bytes);
        logic [9:0] a;
        for (int i = 0; i < bytes; i++) begin
            a = 10'(addr + 32'(i));
            modelMem[a] = data[8*i +: 8];
        end
    endfunction

    task automatic checkEq(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s %s: expected %h actual %h", testName, what, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Drive after the edge, return just before the next one
    task automatic issue(input logic [31:0] instr);
        @(posedge clk);
        #5;
        instruction = instr;
        pcNext = pendingPc;
        #85;
    endtask

    task automatic runWb(input logic [31:0] instr, input logic [4:0] rd,
                         input logic [31:0] expected);
        issue(instr);
        checkEq("wbEn", 32'd1, 32'(wbEn));
        checkEq("wbAddr", 32'(rd), 32'(wbAddr));
        checkEq("wbData", expected, wbData);
        checkEq("memWe", 32'd0, 32'(memWe));
        checkEq("illegal", 32'd0, 32'(illegal));
        if (rd != 5'd0) begin
            modelReg[rd] = expected;
        end
    endtask

    task automatic storeCheck(input logic [31:0] instr, input logic [31:0] addr,
                              input logic [31:0] data, input int bytes);
        issue(instr);
        checkEq("memWe", 32'd1, 32'(memWe));
        checkEq("memAddr", addr, memAddr);
        checkEq("memWdata", data, memWdata);
        checkEq("wbEn", 32'd0, 32'(wbEn));
        checkEq("illegal", 32'd0, 32'(illegal));
        writeModel(addr, data, bytes);
    endtask

    // LUI then ADDI, upper part bumped when ADDI sign-extends a negative low part
    task automatic loadReg(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] upper;
        upper = value[31:12] + {19'b0, value[11]};
        runWb(encU(upper, rd), rd, {upper, 12'h000});
        runWb(encI(value[11:0], rd, f3Add, rd, opImmC), rd, value);
    endtask

    task automatic resetTest();
        testName = "reset";
        for (int c = 0; c < 2; c++) begin
            issue(c == 0 ? encS(12'd8, 5'd0, 5'd0, f3Word) :
                           encI(12'd1, 5'd0, f3Add, 5'd1, opImmC));
            checkEq("wbEn", 32'd0, 32'(wbEn));
            checkEq("memWe", 32'd0, 32'(memWe));
        end
        @(posedge clk);
        #5;
        rstN = 1'b1;
        instruction = 32'h0000_0000;
        #85;
        checkEq("wbEn", 32'd0, 32'(wbEn));
        checkEq("memWe", 32'd0, 32'(memWe));
        for (int r = 1; r < 32; r++) begin
            runWb(encI(12'd0, 5'(r), f3Add, 5'(r), opImmC), 5'(r), 32'd0);
        end
    endtask

    task automatic opImmTest();
        string names [9] = '{"ADDI", "SLLI", "SLTI", "SLTIU", "XORI", "SRLI", "ORI",
                             "ANDI", "SRAI"};
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rs1;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] r;
        logic [11:0] imm;
        for (int k = 0; k < 9; k++) begin
            f3 = (k == 8) ? 3'd5 : 3'(k);
            alt = (k == 8);
            testName = names[k];
            for (int n = 0; n < rounds; n++) begin
                rs1 = randomReg();
                rd = randomReg();
                a = nextRandom();
                if (n[0]) begin
                    a[31] = 1'b1;
                end
                r = nextRandom();
                imm = r[11:0];
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {alt ? f7Alt : f7Base, r[4:0]};
                end
                loadReg(rs1, a);
                runWb(encI(imm, rs1, f3, rd, opImmC), rd,
                      refAlu(f3, alt, modelReg[rs1], sext12(imm)));
            end
        end
    endtask

    task automatic opRegTest();
        string names [10] = '{"ADD", "SLL", "SLT", "SLTU", "XOR", "SRL", "OR", "AND",
                              "SUB", "SRA"};
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] a;
        for (int k = 0; k < 10; k++) begin
            f3 = (k == 8) ? 3'd0 : (k == 9) ? 3'd5 : 3'(k);
            alt = (k >= 8);
            testName = names[k];
            for (int n = 0; n < rounds; n++) begin
                rs1 = randomReg();
                rs2 = rs1 % 5'd31 + 5'd1;
                rd = randomReg();
                a = nextRandom();
                if (!n[0]) begin
                    a[31] = 1'b1;
                end
                loadReg(rs1, a);
                loadReg(rs2, nextRandom());
                runWb(encR(alt ? f7Alt : f7Base, rs2, rs1, f3, rd), rd,
                      refAlu(f3, alt, modelReg[rs1], modelReg[rs2]));
            end
        end
        // x0 shows the write on the trace but keeps reading zero
        testName = "x0 write";
        runWb(encR(f7Base, rs2, rs1, f3Add, 5'd0), 5'd0, modelReg[rs1] + modelReg[rs2]);
        runWb(encI(12'd0, 5'd0, f3Add, rd, opImmC), rd, 32'd0);
    endtask

    task automatic luiJalTest();
        logic [4:0]  rd;
        logic [31:0] r;
        for (int n = 0; n < rounds; n++) begin
            testName = "LUI";
            rd = randomReg();
            r = nextRandom();
            runWb(encU(r[19:0], rd), rd, {r[19:0], 12'h000});
            testName = "JAL";
            rd = randomReg();
            pendingPc = nextRandom();
            runWb(encJ(r[31:11], rd), rd, pendingPc);
        end
    endtask

    task automatic memTest();
        logic [4:0]  baseReg;
        logic [4:0]  dataReg;
        logic [31:0] base;
        logic [31:0] r;
        logic [31:0] data;
        logic [11:0] off;
        logic [11:0] offH;
        logic [11:0] offB;
        for (int n = 0; n < rounds; n++) begin
            baseReg = randomReg();
            dataReg = baseReg % 5'd31 + 5'd1;
            r = nextRandom();
            base = r & 32'h0000_03fc;
            // Word offset in -128..124, then half and byte lanes inside that word
            off = {{4{r[17]}}, r[17:12], 2'b00};
            offH = off + {10'b0, r[20], 1'b0};
            offB = off + {10'b0, r[22:21]};
            loadReg(baseReg, base);
            testName = "SW";
            data = nextRandom();
            loadReg(dataReg, data);
            storeCheck(encS(off, dataReg, baseReg, f3Word), base + sext12(off), data, 4);
            testName = "SH";
            data = nextRandom();
            loadReg(dataReg, data);
            storeCheck(encS(offH, dataReg, baseReg, f3Half), base + sext12(offH), data, 2);
            testName = "SB";
            data = nextRandom();
            loadReg(dataReg, data);
            storeCheck(encS(offB, dataReg, baseReg, f3Byte), base + sext12(offB), data, 1);
            testName = "LB";
            runWb(encI(offB, baseReg, f3Byte, dataReg, opLoadC), dataReg,
                  readModel(base + sext12(offB), 1, 1'b0));
            testName = "LH";
            runWb(encI(offH, baseReg, f3Half, dataReg, opLoadC), dataReg,
                  readModel(base + sext12(offH), 2, 1'b0));
            testName = "LW";
            runWb(encI(off, baseReg, f3Word, dataReg, opLoadC), dataReg,
                  readModel(base + sext12(off), 4, 1'b0));
            testName = "LBU";
            runWb(encI(offB, baseReg, f3ByteU, dataReg, opLoadC), dataReg,
                  readModel(base + sext12(offB), 1, 1'b1));
            testName = "LHU";
            runWb(encI(offH, baseReg, f3HalfU, dataReg, opLoadC), dataReg,
                  readModel(base + sext12(offH), 2, 1'b1));
        end
    endtask

    task automatic illegalTest();
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        testName = "illegal";
        rs1 = randomReg();
        rs2 = rs1 % 5'd31 + 5'd1;
        rd = rs2 % 5'd31 + 5'd1;
        loadReg(rs1, nextRandom());
        loadReg(rs2, nextRandom());
        loadReg(rd, nextRandom());
        // BEQ encoding, rd sits where the branch offset low bits go
        issue({7'b0, rs2, rs1, 3'b000, rd, opBranchC});
        checkEq("illegal", 32'd1, 32'(illegal));
        checkEq("wbEn", 32'd0, 32'(wbEn));
        checkEq("memWe", 32'd0, 32'(memWe));
        runWb(encI(12'd0, rs1, f3Add, rs1, opImmC), rs1, modelReg[rs1]);
        runWb(encI(12'd0, rs2, f3Add, rs2, opImmC), rs2, modelReg[rs2]);
        runWb(encI(12'd0, rd, f3Add, rd, opImmC), rd, modelReg[rd]);
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        instruction = encI(12'd1, 5'd0, f3Add, 5'd1, opImmC);
        pcNext = '0;
        pendingPc = '0;
        rngState = 32'd85;
        for (int i = 0; i < 32; i++) begin
            modelReg[i] = '0;
        end
        resetTest();
        opImmTest();
        opRegTest();
        luiJalTest();
        memTest();
        illegalTest();
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("Timeout: the run did not finish within %0d ns", watchdogNs);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: vlog.f
src/rvPkg.sv
src/controlUnit.sv
src/immediateGenerator.sv
src/alu.sv
src/registerFile.sv
src/dataMemory.sv
src/singleCycleCore.sv
sim/coreTb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= coreTb
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
